/* sources.f */
source/cpu_pkg.sv
source/alu.sv
source/memory_unit.sv
source/datapath.sv
source/control_sequencer.sv
source/cpu_top.sv
tests/cpu_tb.sv

/* Bender.yml */
package:
  name: accumulator_cpu

sources:
  - source/cpu_pkg.sv
  - source/alu.sv
  - source/memory_unit.sv
  - source/datapath.sv
  - source/control_sequencer.sv
  - source/cpu_top.sv
  - target: test
    files:
      - tests/cpu_tb.sv

/* tests/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;

    localparam int max_wait = 4000;
    localparam int n_rows = 15;

    // one program shape per test kind
    typedef enum logic [2:0] {k_add, k_sub, k_jc, k_jz, k_sta, k_loop} kind_t;
    // rnd rows replace x and y, fixed rows also carry a first output and a count
    typedef struct packed {
        kind_t      kind;
        logic       rnd;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] exp_first;
        logic [7:0] exp_count;
    } row_t;

    row_t rows [n_rows] = '{
        '{k_add,  1'b0, 8'd200, 8'd100, 8'd44,  8'd1},
        '{k_sub,  1'b0, 8'd5,   8'd9,   8'd252, 8'd1},
        '{k_jc,   1'b0, 8'd9,   8'd5,   8'd2,   8'd1},
        '{k_jc,   1'b0, 8'd5,   8'd9,   8'd1,   8'd1},
        '{k_jc,   1'b0, 8'd7,   8'd7,   8'd2,   8'd1},
        '{k_jz,   1'b0, 8'd200, 8'd56,  8'd2,   8'd1},
        '{k_jz,   1'b0, 8'd3,   8'd4,   8'd1,   8'd1},
        '{k_sta,  1'b0, 8'ha5,  8'd0,   8'ha5,  8'd1},
        '{k_loop, 1'b0, 8'd5,   8'd0,   8'd5,   8'd5},
        '{k_add,  1'b1, 8'd0,   8'd0,   8'd0,   8'd0},
        '{k_sub,  1'b1, 8'd0,   8'd0,   8'd0,   8'd0},
        '{k_jc,   1'b1, 8'd0,   8'd0,   8'd0,   8'd0},
        '{k_jz,   1'b1, 8'd0,   8'd0,   8'd0,   8'd0},
        '{k_sta,  1'b1, 8'd0,   8'd0,   8'd0,   8'd0},
        '{k_loop, 1'b1, 8'd0,   8'd0,   8'd0,   8'd0}
    };

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  prog_mode;
    cpu_pkg::prog_write_t  prog;
    logic [7:0]            out_value;
    logic                  out_strobe;
    logic                  halted;
    logic [31:0]           seed = 32'hee0d;
    // program image, expected and collected outputs
    logic [7:0]            prog_img [16];
    logic [7:0]            exp_q [$];
    logic [7:0]            got_q [$];
    // instructions executed before hlt
    int                    exp_instrs;

    cpu_top uut (
        .clk        (clk),
        .reset      (reset),
        .prog_mode  (prog_mode),
        .prog       (prog),
        .out_value  (out_value),
        .out_strobe (out_strobe),
        .halted     (halted)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function automatic logic [7:0] encode(input cpu_pkg::opcode_t op, input logic [3:0] arg);
        return {op, arg};
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s (got %0d, expected %0d)", $time, msg, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic build_program(input kind_t kind, input logic [7:0] x, input logic [7:0] y);
        int i;
        // unused words hold opcode 9, a nop, tagged with their address
        for (i = 0; i < 16; i++) begin
            prog_img[i] = {4'd9, i[3:0]};
        end
        prog_img[14] = x;
        prog_img[15] = y;
        case (kind)
            k_add, k_sub: begin
                prog_img[0] = encode(cpu_pkg::op_lda, 4'd14);
                prog_img[1] = encode(kind == k_add ? cpu_pkg::op_add : cpu_pkg::op_sub, 4'd15);
                prog_img[2] = encode(cpu_pkg::op_out, 4'd0);
                prog_img[3] = encode(cpu_pkg::op_hlt, 4'd0);
            end
            k_jc, k_jz: begin
                // marker 1 on fall through, marker 2 when taken
                prog_img[0] = encode(cpu_pkg::op_lda, 4'd14);
                prog_img[1] = encode(kind == k_jc ? cpu_pkg::op_sub : cpu_pkg::op_add, 4'd15);
                prog_img[2] = encode(kind == k_jc ? cpu_pkg::op_jc : cpu_pkg::op_jz, 4'd6);
                prog_img[3] = encode(cpu_pkg::op_ldi, 4'd1);
                prog_img[4] = encode(cpu_pkg::op_out, 4'd0);
                prog_img[5] = encode(cpu_pkg::op_hlt, 4'd0);
                prog_img[6] = encode(cpu_pkg::op_ldi, 4'd2);
                prog_img[7] = encode(cpu_pkg::op_out, 4'd0);
                prog_img[8] = encode(cpu_pkg::op_hlt, 4'd0);
            end
            k_sta: begin
                // ldi 0 clears a so the value has to come back from ram
                prog_img[0] = encode(cpu_pkg::op_lda, 4'd14);
                prog_img[1] = encode(cpu_pkg::op_sta, 4'd13);
                prog_img[2] = encode(cpu_pkg::op_ldi, 4'd0);
                prog_img[3] = encode(cpu_pkg::op_lda, 4'd13);
                prog_img[4] = encode(cpu_pkg::op_out, 4'd0);
                prog_img[5] = encode(cpu_pkg::op_hlt, 4'd0);
            end
            default: begin
                // countdown from x to 1
                prog_img[0] = encode(cpu_pkg::op_ldi, x[3:0]);
                prog_img[1] = encode(cpu_pkg::op_out, 4'd0);
                prog_img[2] = encode(cpu_pkg::op_sub, 4'd15);
                prog_img[3] = encode(cpu_pkg::op_jz, 4'd5);
                prog_img[4] = encode(cpu_pkg::op_jmp, 4'd1);
                prog_img[5] = encode(cpu_pkg::op_hlt, 4'd0);
                prog_img[15] = 8'd1;
            end
        endcase
    endtask

    // instruction level model of the isa
    task automatic run_model();
        logic [7:0] m [16];
        logic [7:0] a;
        logic [7:0] ins;
        logic [3:0] pc;
        logic       c;
        logic       z;
        logic       done;
        int         steps;
        m = prog_img;
        a = '0;
        pc = '0;
        c = 1'b0;
        z = 1'b0;
        done = 1'b0;
        steps = 0;
        exp_q.delete();
        while (!done && steps < max_wait) begin
            ins = m[pc];
            pc = pc + 4'd1;
            steps++;
            case (cpu_pkg::opcode_t'(ins[7:4]))
                cpu_pkg::op_lda: a = m[ins[3:0]];
                cpu_pkg::op_add: begin
                    {c, a} = a + m[ins[3:0]];
                    z = (a == 8'd0);
                end
                cpu_pkg::op_sub: begin
                    // carry means no borrow
                    c = (a >= m[ins[3:0]]);
                    a = a - m[ins[3:0]];
                    z = (a == 8'd0);
                end
                cpu_pkg::op_sta: m[ins[3:0]] = a;
                cpu_pkg::op_ldi: a = {4'd0, ins[3:0]};
                cpu_pkg::op_jmp: pc = ins[3:0];
                cpu_pkg::op_jc:  pc = c ? ins[3:0] : pc;
                cpu_pkg::op_jz:  pc = z ? ins[3:0] : pc;
                cpu_pkg::op_out: exp_q.push_back(a);
                cpu_pkg::op_hlt: done = 1'b1;
                default: ;
            endcase
        end
        exp_instrs = steps - 1;
    endtask

    // park the cpu, optionally rewrite all 16 words, then release
    task automatic load_program(input logic do_write);
        int i;
        @(posedge clk);
        prog_mode <= 1'b1;
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            prog <= {do_write, i[3:0], prog_img[i]};
            @(negedge clk);
            check(halted, 1'b0, "halted high in program mode");
            check(out_strobe, 1'b0, "out_strobe high in program mode");
        end
        @(posedge clk);
        prog <= '0;
        prog_mode <= 1'b0;
    endtask

    // edges counts rising edges after the release until halted shows
    task automatic run_collect(output int edges);
        int i;
        edges = 0;
        got_q.delete();
        while (1) begin
            @(negedge clk);
            if (out_strobe) begin
                got_q.push_back(out_value);
            end
            if (halted) begin
                break;
            end
            edges++;
            if (edges > max_wait) begin
                $display("Timeout: CPU did not halt within %0d cycles", max_wait);
                $display("Simulation FAILED");
                $fatal(1, "halt timeout");
            end
        end
        // the halted cpu stays quiet
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            check(out_strobe, 1'b0, "out_strobe after halt");
            check(halted, 1'b1, "halted dropped without program mode");
        end
    endtask

    initial begin
        row_t       r;
        logic [7:0] x;
        logic [7:0] y;
        int         n;
        int         pass;
        int         edges;
        int         k;
        reset = 1'b1;
        prog_mode = 1'b1;
        prog = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        // idle after reset with the cpu parked
        repeat (3) begin
            @(negedge clk);
            check(out_value, 8'd0, "out_value after reset");
            check(out_strobe, 1'b0, "out_strobe after reset");
            check(halted, 1'b0, "halted after reset");
        end
        for (n = 0; n < n_rows; n++) begin
            r = rows[n];
            x = r.x;
            y = r.y;
            if (r.rnd) begin
                seed = xorshift(seed);
                x = seed[7:0];
                seed = xorshift(seed);
                y = seed[7:0];
                // ldi takes 4 bits and the countdown needs a start above zero
                if (r.kind == k_loop) begin
                    x = x % 8'd15 + 8'd1;
                end
            end
            build_program(r.kind, x, y);
            run_model();
            if (!r.rnd) begin
                check(exp_q.size(), r.exp_count, "model output count against table");
                check(exp_q[0], r.exp_first, "model first output against table");
            end
            // second pass restarts from address zero without new writes
            for (pass = 0; pass < 2; pass++) begin
                load_program(pass == 0);
                run_collect(edges);
                check(edges, 5 * exp_instrs + 3, "cycles from release to halted");
                check(got_q.size(), exp_q.size(), "number of out strobes");
                for (k = 0; k < got_q.size(); k++) begin
                    check(got_q[k], exp_q[k], "out_value");
                end
            end
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            prog_mode,
    input  cpu_pkg::prog_write_t            prog,
    output logic [cpu_pkg::data_width-1:0]  out_value,
    output logic                            out_strobe,
    output logic                            halted
);

    // control word from the sequencer
    cpu_pkg::ctrl_word_t            ctrl;
    // shared internal bus and ram read data
    logic [cpu_pkg::data_width-1:0] bus;
    logic [cpu_pkg::data_width-1:0] ram_data;
    // decode feedback from the datapath
    cpu_pkg::opcode_t               opcode;
    logic                           carry;
    logic                           zero;

    control_sequencer seq_i (
        .clk       (clk),
        .reset     (reset),
        .prog_mode (prog_mode),
        .opcode    (opcode),
        .carry     (carry),
        .zero      (zero),
        .ctrl      (ctrl),
        .halted    (halted)
    );

    datapath dp_i (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .ram_data   (ram_data),
        .bus        (bus),
        .opcode     (opcode),
        .carry      (carry),
        .zero       (zero),
        .out_value  (out_value),
        .out_strobe (out_strobe)
    );

    memory_unit mem_i (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .bus       (bus),
        .prog      (prog),
        .prog_mode (prog_mode),
        .ram_data  (ram_data)
    );

endmodule

/* source/control_sequencer.sv */
`timescale 1ns/100ps

module control_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 prog_mode,
    input  cpu_pkg::opcode_t     opcode,
    input  logic                 carry,
    input  logic                 zero,
    output cpu_pkg::ctrl_word_t  ctrl,
    output logic                 halted
);

    cpu_pkg::step_t step;
    logic           prog_mode_q;
    // first cycle out of program mode
    logic           prog_fall;
    logic           halt_set;

    assign prog_fall = prog_mode_q && !prog_mode;

    // delayed program mode for the edge detect
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_mode_q <= 1'b0;
        end else begin
            prog_mode_q <= prog_mode;
        end
    end

    // microstep counter held at t0 in program mode
    // and frozen once halted
    always_ff @(posedge clk) begin
        if (reset || prog_mode) begin
            step <= cpu_pkg::t0;
        end else if (!halted) begin
            case (step)
                cpu_pkg::t0: step <= cpu_pkg::t1;
                cpu_pkg::t1: step <= cpu_pkg::t2;
                cpu_pkg::t2: step <= cpu_pkg::t3;
                cpu_pkg::t3: step <= cpu_pkg::t4;
                default:     step <= cpu_pkg::t0;
            endcase
        end
    end

    // halt latch cleared by reset or a new program load
    always_ff @(posedge clk) begin
        if (reset || prog_mode) begin
            halted <= 1'b0;
        end else if (halt_set) begin
            halted <= 1'b1;
        end
    end

    // decode step and opcode into the control word
    always_comb begin
        ctrl     = '0;
        halt_set = 1'b0;
        if (prog_mode || halted) begin
            // idle so the control word stays zero
        end else if (prog_fall) begin
            // restart fetch at address zero
            // empty bus clears both pc and mar
            ctrl.bus_src  = cpu_pkg::bus_none;
            ctrl.mar_load = 1'b1;
            ctrl.pc_load  = 1'b1;
        end else begin
            case (step)
                cpu_pkg::t0: begin
                    ctrl.bus_src  = cpu_pkg::bus_pc;
                    ctrl.mar_load = 1'b1;
                end
                cpu_pkg::t1: begin
                    ctrl.bus_src = cpu_pkg::bus_ram;
                    ctrl.ir_load = 1'b1;
                    ctrl.pc_inc  = 1'b1;
                end
                cpu_pkg::t2: begin
                    case (opcode)
                        cpu_pkg::op_lda, cpu_pkg::op_add,
                        cpu_pkg::op_sub, cpu_pkg::op_sta: begin
                            ctrl.bus_src  = cpu_pkg::bus_operand;
                            ctrl.mar_load = 1'b1;
                        end
                        cpu_pkg::op_ldi: begin
                            ctrl.bus_src = cpu_pkg::bus_operand;
                            ctrl.a_load  = 1'b1;
                        end
                        cpu_pkg::op_jmp: begin
                            ctrl.bus_src = cpu_pkg::bus_operand;
                            ctrl.pc_load = 1'b1;
                        end
                        // conditional jumps use the flags as they are now
                        cpu_pkg::op_jc: begin
                            ctrl.bus_src = cpu_pkg::bus_operand;
                            ctrl.pc_load = carry;
                        end
                        cpu_pkg::op_jz: begin
                            ctrl.bus_src = cpu_pkg::bus_operand;
                            ctrl.pc_load = zero;
                        end
                        cpu_pkg::op_out: begin
                            ctrl.bus_src  = cpu_pkg::bus_acc;
                            ctrl.out_load = 1'b1;
                        end
                        cpu_pkg::op_hlt: halt_set = 1'b1;
                        default: ;
                    endcase
                end
                cpu_pkg::t3: begin
                    case (opcode)
                        cpu_pkg::op_lda: begin
                            ctrl.bus_src = cpu_pkg::bus_ram;
                            ctrl.a_load  = 1'b1;
                        end
                        cpu_pkg::op_add, cpu_pkg::op_sub: begin
                            ctrl.bus_src = cpu_pkg::bus_ram;
                            ctrl.b_load  = 1'b1;
                        end
                        cpu_pkg::op_sta: begin
                            ctrl.bus_src   = cpu_pkg::bus_acc;
                            ctrl.ram_write = 1'b1;
                        end
                        default: ;
                    endcase
                end
                default: begin
                    // t4 writes back the alu result
                    if (opcode == cpu_pkg::op_add || opcode == cpu_pkg::op_sub) begin
                        ctrl.bus_src    = cpu_pkg::bus_alu;
                        ctrl.alu_sub    = (opcode == cpu_pkg::op_sub);
                        ctrl.a_load     = 1'b1;
                        ctrl.flags_load = 1'b1;
                    end
                end
            endcase
        end
    end

    // counter only ever holds t0 through t4
    a_step_range: assert property (@(posedge clk) disable iff (reset)
        step <= cpu_pkg::t4);

    // once halted nothing moves until program mode
    a_halt_frozen: assert property (@(posedge clk) disable iff (reset)
        (halted && !prog_mode) |=> ($stable(step) && ctrl == '0));

endmodule

/* source/datapath.sv */
`timescale 1ns/100ps

module datapath (
    input  logic                            clk,
    input  logic                            reset,
    input  cpu_pkg::ctrl_word_t             ctrl,
    input  logic [cpu_pkg::data_width-1:0]  ram_data,
    output logic [cpu_pkg::data_width-1:0]  bus,
    output cpu_pkg::opcode_t                opcode,
    output logic                            carry,
    output logic                            zero,
    output logic [cpu_pkg::data_width-1:0]  out_value,
    output logic                            out_strobe
);

    logic [cpu_pkg::addr_width-1:0] pc;
    // ir holds opcode in the upper nibble
    logic [cpu_pkg::data_width-1:0] ir;
    logic [cpu_pkg::data_width-1:0] reg_a;
    logic [cpu_pkg::data_width-1:0] reg_b;
    logic [cpu_pkg::data_width-1:0] alu_result;
    logic                           alu_carry;
    logic                           alu_zero;
    logic [cpu_pkg::addr_width-1:0] operand;

    assign opcode  = cpu_pkg::opcode_t'(ir[cpu_pkg::data_width-1:cpu_pkg::addr_width]);
    assign operand = ir[cpu_pkg::addr_width-1:0];

    alu alu_i (
        .a      (reg_a),
        .b      (reg_b),
        .sub    (ctrl.alu_sub),
        .result (alu_result),
        .carry  (alu_carry),
        .zero   (alu_zero)
    );

    // bus multiplexer in place of tri-state drivers
    always_comb begin
        case (ctrl.bus_src)
            cpu_pkg::bus_pc:      bus = {{(cpu_pkg::data_width-cpu_pkg::addr_width){1'b0}}, pc};
            cpu_pkg::bus_ram:     bus = ram_data;
            cpu_pkg::bus_operand: bus = {{(cpu_pkg::data_width-cpu_pkg::addr_width){1'b0}}, operand};
            cpu_pkg::bus_acc:     bus = reg_a;
            cpu_pkg::bus_alu:     bus = alu_result;
            default:              bus = '0;
        endcase
    end

    // program counter, load wins over increment
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            pc <= bus[cpu_pkg::addr_width-1:0];
        end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    // instruction, accumulator and b registers
    always_ff @(posedge clk) begin
        if (reset) begin
            ir    <= '0;
            reg_a <= '0;
            reg_b <= '0;
        end else begin
            if (ctrl.ir_load) begin
                ir <= bus;
            end
            if (ctrl.a_load) begin
                reg_a <= bus;
            end
            if (ctrl.b_load) begin
                reg_b <= bus;
            end
        end
    end

    // flags only change on add and sub writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (ctrl.flags_load) begin
            carry <= alu_carry;
            zero  <= alu_zero;
        end
    end

    // output register and its one-cycle strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            out_value  <= '0;
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= ctrl.out_load;
            if (ctrl.out_load) begin
                out_value <= bus;
            end
        end
    end

    // register loads always have a real bus driver
    a_load_has_src: assert property (@(posedge clk) disable iff (reset)
        (ctrl.a_load || ctrl.b_load || ctrl.ir_load || ctrl.out_load)
        |-> ctrl.bus_src != cpu_pkg::bus_none);

    // strobe never stretches past one cycle
    a_strobe_pulse: assert property (@(posedge clk) disable iff (reset)
        out_strobe |=> !out_strobe);

endmodule

/* source/memory_unit.sv */
`timescale 1ns/100ps

module memory_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  cpu_pkg::ctrl_word_t             ctrl,
    input  logic [cpu_pkg::data_width-1:0]  bus,
    input  cpu_pkg::prog_write_t            prog,
    input  logic                            prog_mode,
    output logic [cpu_pkg::data_width-1:0]  ram_data
);

    // memory address register
    logic [cpu_pkg::addr_width-1:0] mar;
    // 16 x 8 program and data store
    logic [cpu_pkg::data_width-1:0] mem [cpu_pkg::mem_depth];

    // mar takes the low nibble of the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            mar <= '0;
        end else if (ctrl.mar_load) begin
            mar <= bus[cpu_pkg::addr_width-1:0];
        end
    end

    // programming port has priority over the cpu
    always_ff @(posedge clk) begin
        if (prog_mode) begin
            if (prog.write) begin
                mem[prog.addr] <= prog.data;
            end
        end else if (ctrl.ram_write) begin
            // sta writes the accumulator at the mar
            mem[mar] <= bus;
        end
    end

    // asynchronous read at the current mar
    assign ram_data = mem[mar];

    // host may only write while the cpu is parked
    a_prog_write_mode: assert property (@(posedge clk) disable iff (reset)
        prog.write |-> prog_mode);

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu (
    input  logic [cpu_pkg::data_width-1:0] a,
    input  logic [cpu_pkg::data_width-1:0] b,
    input  logic                           sub,
    output logic [cpu_pkg::data_width-1:0] result,
    output logic                           carry,
    output logic                           zero
);

    // second operand after optional inversion
    logic [cpu_pkg::data_width-1:0] b_eff;
    // one extra bit holds the carry-out
    logic [cpu_pkg::data_width:0]   sum;

    // subtract as a + ~b + 1
    assign b_eff = sub ? ~b : b;

    always_comb begin
        sum = {1'b0, a} + {1'b0, b_eff} + {{cpu_pkg::data_width{1'b0}}, sub};
    end

    assign result = sum[cpu_pkg::data_width-1:0];

    // for sub this is the no-borrow flag
    // set when a >= b
    assign carry = sum[cpu_pkg::data_width];

    // zero flag from the truncated result
    assign zero = (result == '0);

endmodule

/* source/cpu_pkg.sv */
package cpu_pkg;

    // data word and address sizes
    localparam int data_width = 8;
    localparam int addr_width = 4;
    // one ram word per address
    localparam int mem_depth = 1 << addr_width;

    // upper nibble of the instruction word
    // codes 9..13 are unused and decode as nop
    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_lda = 4'd1,
        op_add = 4'd2,
        op_sub = 4'd3,
        op_sta = 4'd4,
        op_ldi = 4'd5,
        op_jmp = 4'd6,
        op_jc  = 4'd7,
        op_jz  = 4'd8,
        op_out = 4'd14,
        op_hlt = 4'd15
    } opcode_t;

    // five microsteps per instruction
    // t0 and t1 are the shared fetch
    typedef enum logic [2:0] {
        t0 = 3'd0,
        t1 = 3'd1,
        t2 = 3'd2,
        t3 = 3'd3,
        t4 = 3'd4
    } step_t;

    // which block drives the internal bus
    // bus_none reads as all zeros
    typedef enum logic [2:0] {
        bus_none    = 3'd0,
        bus_pc      = 3'd1,
        bus_ram     = 3'd2,
        bus_operand = 3'd3,
        bus_acc     = 3'd4,
        bus_alu     = 3'd5
    } bus_src_t;

    // one control word per clock, all strobes active high
    typedef struct packed {
        bus_src_t bus_src;
        logic     pc_inc;
        logic     pc_load;
        logic     mar_load;
        logic     ram_write;
        logic     ir_load;
        logic     a_load;
        logic     b_load;
        logic     alu_sub;
        logic     flags_load;
        logic     out_load;
    } ctrl_word_t;

    // programming port into the ram
    typedef struct packed {
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } prog_write_t;

endpackage
